/* filelist.f */
hw/l1_dcache_pkg.sv
hw/l1_tag_stage.sv
hw/l1_d_data_array.sv
hw/l1_miss_ctrl.sv
hw/l1_dcache_top.sv
testbench/tb_clock_gen.sv
testbench/l1_dcache_props.sv
testbench/l1_dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the L1 data cache testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module l1_dcache_tb -f filelist.f \
    && ./obj_dir/Vl1_dcache_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log 2>/dev/null
[ "$status" -eq 0 ] && [ -f sim.log ] && ! grep -q "Testbench failed" sim.log \
    && echo "run_sim: simulation clean" && exit 0 \
    || { echo "run_sim: simulation reported a failure"; exit 1; }

/* testbench/l1_dcache_tb.sv */
`timescale 1ns/10ps

module l1_dcache_tb;
    import l1_dcache_pkg::*;

    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic [31:0]       cyc;
        logic              check_lat;
    } exp_rd_t;

    logic              clk;
    logic              nrst;
    logic              req_valid;
    core_req_t         req;
    logic              stall;
    logic              resp_valid;
    logic [WORD_W-1:0] resp_rdata;
    logic              wb_valid;
    logic [WORD_W-1:0] wb_addr;
    logic [LINE_W-1:0] wb_data;
    logic              l2_req;
    logic [WORD_W-1:0] l2_addr;
    logic              l2_ack;
    logic [LINE_W-1:0] l2_rdata;

    logic [WORD_W-1:0] ref_mem [logic [WORD_W-1:0]]; // Program order view of memory.
    logic [LINE_W-1:0] l2_mem [logic [WORD_W-1:0]];
    exp_rd_t           exp_q [$];
    logic [WORD_W-1:0] last_wb_addr;
    logic [LINE_W-1:0] last_wb_data;
    logic [WORD_W-1:0] last_l2_addr;
    int                cyc = 0;
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                l2_req_cnt = 0;
    int                wb_cnt = 0;

    tb_clock_gen clock_gen_i (.clk(clk), .nrst(nrst));

    l1_dcache_top #(
        .NUM_SETS (64)
    ) l1_dcache_top_i (
        .clk        (clk),
        .nrst       (nrst),
        .req_valid  (req_valid),
        .req        (req),
        .stall      (stall),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr),
        .l2_ack     (l2_ack),
        .l2_rdata   (l2_rdata)
    );

    // Initial L2 content, each word a scramble of its full byte address.
    function automatic logic [WORD_W-1:0] l2_word(input logic [WORD_W-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [LINE_W-1:0] l2_line(input logic [WORD_W-1:0] line_addr);
        logic [LINE_W-1:0] data;
        for (int w = 0; w < 16; w++)
            data[w*WORD_W +: WORD_W] = l2_word(line_addr + 32'(w * 4));
        return data;
    endfunction

    function automatic logic [WORD_W-1:0] ref_word(input logic [WORD_W-1:0] addr);
        if (ref_mem.exists(addr))
            return ref_mem[addr];
        return l2_word(addr);
    endfunction

    function automatic int total_errors();
        return errors + int'(l1_dcache_top_i.props_i.fail_cnt);
    endfunction

    task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("Check failed at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (total_errors() == errors_before)
            $display("Test %0d, %s: ok", tests, name);
        else
            $display("Test %0d, %s: %0d errors", tests, name, total_errors() - errors_before);
    endtask

    task automatic send(input logic write, input logic [WORD_W-1:0] addr,
                        input logic [WORD_W-1:0] wdata, input logic check_lat);
        int      n;
        exp_rd_t e;
        n = 0;
        req_valid = 1'b1;
        req       = {write, addr, wdata};
        while (stall && n < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (stall)
            stop_on_timeout("the cache to accept a request");
        if (write)
            ref_mem[addr] = wdata; // Stall stays low until the edge, so this edge takes it.
        else
        begin
            e.data      = ref_word(addr);
            e.cyc       = 32'(cyc) + 32'd1;
            e.check_lat = check_lat;
            exp_q.push_back(e);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // The last request reaches stage 1 one edge after acceptance, then any miss shows as stall.
    task automatic drain();
        int n;
        n = 0;
        @(posedge clk);
        #1;
        while ((exp_q.size() != 0 || stall) && n < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0 || stall)
            stop_on_timeout("outstanding requests to complete");
    endtask

    always @(posedge clk)
        cyc <= cyc + 1;

    always @(negedge clk)
    begin : resp_monitor
        exp_rd_t e;
        if (resp_valid)
        begin
            if (exp_q.size() == 0)
                check_true(1'b0, "a read response arrived with no read outstanding");
            else
            begin
                e = exp_q.pop_front();
                check_value("resp_rdata", resp_rdata, e.data);
                if (e.check_lat)
                    check_value("hit latency", 32'(cyc) - e.cyc, 32'd2);
            end
        end
    end

    // L2 model. Stores victims and answers each fetch after 1 to 6 cycles.
    initial
    begin : l2_model
        int                delay;
        logic [WORD_W-1:0] addr;
        l2_ack   = 1'b0;
        l2_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (wb_valid)
            begin
                l2_mem[wb_addr] = wb_data;
                last_wb_addr    = wb_addr;
                last_wb_data    = wb_data;
                wb_cnt++;
            end
            if (l2_req)
            begin
                l2_req_cnt++;
                addr         = l2_addr;
                last_l2_addr = l2_addr;
                delay        = $urandom_range(6, 1);
                repeat (delay) @(posedge clk);
                #1;
                l2_ack   = 1'b1;
                l2_rdata = l2_mem.exists(addr) ? l2_mem[addr] : l2_line(addr);
                @(posedge clk);
                #1;
                l2_ack = 1'b0;
            end
        end
    end

    initial
    begin : stimulus
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        int                e0;
        int                l2_before;
        int                wb_before;
        int                n;
        void'($urandom(32'heefe));
        req_valid = 1'b0;
        req       = '0;
        a         = 32'h0000_1040; // Set 1.
        b         = a + 32'h0001_0000; // Same set, other tag.
        n         = 0;
        while (nrst !== 1'b1 && n < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (nrst !== 1'b1)
            stop_on_timeout("reset release");
        check_true(!stall && !resp_valid && !wb_valid && !l2_req, "an output was high after reset");

        e0        = total_errors();
        l2_before = l2_req_cnt;
        send(1'b0, a + 32'd4, '0, 1'b0);
        drain();
        check_value("l2_req count", 32'(l2_req_cnt - l2_before), 32'd1);
        check_value("l2_addr", last_l2_addr, (a + 32'd4) & ~32'h3f);
        finish_test("first read misses and fills from L2", e0);

        e0 = total_errors();
        send(1'b1, a + 32'd8, 32'h1234_5678, 1'b0);
        send(1'b0, a + 32'd8, '0, 1'b0);
        send(1'b1, a + 32'd12, 32'hcafe_0001, 1'b0);
        drain();
        send(1'b0, a + 32'd12, '0, 1'b0);
        drain();
        finish_test("read after write", e0);

        e0 = total_errors();
        for (int i = 0; i < 16; i++)
            send(1'b0, a + 32'(i * 4), '0, 1'b1);
        drain();
        finish_test("back-to-back hit reads", e0);

        e0 = total_errors();
        send(1'b1, a + 32'd60, 32'h0bad_f00d, 1'b0);
        wb_before = wb_cnt;
        send(1'b0, b, '0, 1'b0);
        drain();
        check_value("wb_valid count", 32'(wb_cnt - wb_before), 32'd1);
        check_value("wb_addr", last_wb_addr, a & ~32'h3f);
        for (int w = 0; w < 16; w++)
            check_value($sformatf("wb_data word %0d", w), last_wb_data[w*WORD_W +: WORD_W],
                        ref_word((a & ~32'h3f) + 32'(w * 4)));
        finish_test("dirty victim written back", e0);

        e0        = total_errors();
        l2_before = l2_req_cnt;
        wb_before = wb_cnt;
        send(1'b0, a + 32'd60, '0, 1'b0);
        send(1'b0, a + 32'd8, '0, 1'b0);
        drain();
        check_value("l2_req count", 32'(l2_req_cnt - l2_before), 32'd1);
        check_value("l2_addr", last_l2_addr, a & ~32'h3f);
        check_value("wb_valid count", 32'(wb_cnt - wb_before), 32'd0);
        finish_test("re-read of evicted line", e0);

        e0 = total_errors();
        for (int i = 0; i < 200; i++)
        begin
            addr  = $urandom_range(3, 0) << 12;
            addr |= ($urandom_range(1, 0) + 32'd4) << 6;
            addr |= $urandom_range(3, 0) << 2;
            wdata = $urandom();
            send($urandom_range(1, 0) == 1, addr, wdata, 1'b0);
        end
        drain();
        finish_test("random reads and writes", e0);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, total_errors());
        if (total_errors() == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* testbench/l1_dcache_props.sv */
`timescale 1ns/10ps

module l1_dcache_props (
    input logic                     clk,
    input logic                     nrst,
    input logic                     req_valid,
    input l1_dcache_pkg::core_req_t req,
    input logic                     stall,
    input logic                     resp_valid,
    input logic                     wb_valid,
    input logic                     l2_req
);
    int unsigned fail_cnt = 0;

    logic accept_rd;

    assign accept_rd = req_valid && !stall && !req.write;

    // Writeback and fetch come from different FSM states.
    wb_fetch_apart: assert property (@(posedge clk) disable iff (!nrst) !(wb_valid && l2_req))
    else
    begin
        $error("wb_valid and l2_req were high in the same cycle");
        fail_cnt++;
    end

    fetch_in_stall: assert property (@(posedge clk) disable iff (!nrst) l2_req |-> stall)
    else
    begin
        $error("l2_req was issued while the core was not stalled");
        fail_cnt++;
    end

    // A read taken with no miss ahead of it, and hitting in stage 1, answers two edges later.
    hit_read_latency: assert property (@(posedge clk) disable iff (!nrst)
        ($past(accept_rd, 2) && !$past(stall) && !stall) |=> resp_valid)
    else
    begin
        $error("resp_valid did not follow an accepted hit read two edges later");
        fail_cnt++;
    end

endmodule

bind l1_dcache_top l1_dcache_props props_i (
    .clk        (clk),
    .nrst       (nrst),
    .req_valid  (req_valid),
    .req        (req),
    .stall      (stall),
    .resp_valid (resp_valid),
    .wb_valid   (wb_valid),
    .l2_req     (l2_req)
);

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic nrst
);
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset lets go on a falling edge, away from the rising edges the stimulus works on.
    initial
    begin
        nrst = 1'b0;
        #(RESET_CYCLES * PERIOD) nrst = 1'b1;
    end

endmodule

/* hw/l1_dcache_top.sv */
`timescale 1ns/10ps

module l1_dcache_top #(
    parameter int NUM_SETS = 64
) (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             req_valid,
    input  l1_dcache_pkg::core_req_t         req,
    output logic                             stall,
    output logic                             resp_valid,
    output logic [l1_dcache_pkg::WORD_W-1:0] resp_rdata,
    output logic                             wb_valid,
    output logic [l1_dcache_pkg::WORD_W-1:0] wb_addr,
    output logic [l1_dcache_pkg::LINE_W-1:0] wb_data,
    output logic                             l2_req,
    output logic [l1_dcache_pkg::WORD_W-1:0] l2_addr,
    input  logic                             l2_ack,
    input  logic [l1_dcache_pkg::LINE_W-1:0] l2_rdata
);
    import l1_dcache_pkg::*;

    stage1_t           s1;
    logic [LINE_W-1:0] victim_line;
    logic              refill;
    logic              tag_fill;
    logic              replay;

    l1_tag_stage #(
        .NUM_SETS (NUM_SETS)
    ) tag_stage_i (
        .clk       (clk),
        .nrst      (nrst),
        .req_valid (req_valid),
        .req       (req),
        .tag_fill  (tag_fill),
        .replay    (replay),
        .s1        (s1),
        .stall     (stall)
    );

    l1_d_data_array #(
        .NUM_SETS (NUM_SETS)
    ) data_array_i (
        .clk         (clk),
        .nrst        (nrst),
        .s1          (s1),
        .refill      (refill),
        .l2_rdata    (l2_rdata),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .victim_line (victim_line)
    );

    l1_miss_ctrl miss_ctrl_i (
        .clk         (clk),
        .nrst        (nrst),
        .s1          (s1),
        .victim_line (victim_line),
        .l2_ack      (l2_ack),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .l2_req      (l2_req),
        .l2_addr     (l2_addr),
        .refill      (refill),
        .tag_fill    (tag_fill),
        .replay      (replay)
    );

endmodule

/* hw/l1_miss_ctrl.sv */
`timescale 1ns/10ps

module l1_miss_ctrl (
    input  logic                             clk,
    input  logic                             nrst,
    input  l1_dcache_pkg::stage1_t           s1,
    input  logic [l1_dcache_pkg::LINE_W-1:0] victim_line,
    input  logic                             l2_ack,
    output logic                             wb_valid,
    output logic [l1_dcache_pkg::WORD_W-1:0] wb_addr,
    output logic [l1_dcache_pkg::LINE_W-1:0] wb_data,
    output logic                             l2_req,
    output logic [l1_dcache_pkg::WORD_W-1:0] l2_addr,
    output logic                             refill,
    output logic                             tag_fill,
    output logic                             replay
);
    import l1_dcache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_writeback,
        st_fetch,
        st_wait_ack,
        st_replay
    } miss_state_t;

    miss_state_t state;
    miss_state_t state_nxt;

    logic miss;

    // The stage-1 entry stays frozen by the stall for the whole sequence.
    assign miss = s1.valid && !s1.hit;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (miss)
                    state_nxt = s1.victim_dirty ? st_writeback : st_fetch;
            end
            st_writeback:
                state_nxt = st_fetch;
            st_fetch:
                state_nxt = st_wait_ack;
            st_wait_ack:
            begin
                if (l2_ack)
                    state_nxt = st_replay;
            end
            st_replay:
                state_nxt = st_idle; // Entry turns into a hit at this edge.
            default:
                state_nxt = st_idle;
        endcase
    end

    // Victim goes out as one strobe, L2 takes it without an acknowledge.
    assign wb_valid = (state == st_writeback);
    assign wb_addr  = {s1.victim_tag, {OFFSET_W{1'b0}}};
    assign wb_data  = victim_line;

    assign l2_req  = (state == st_fetch);
    assign l2_addr = {s1.addr[WORD_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // Line data and tag are installed together on the acknowledge edge.
    assign refill   = (state == st_wait_ack) && l2_ack;
    assign tag_fill = refill;
    assign replay   = (state == st_replay);

endmodule

/* hw/l1_d_data_array.sv */
`timescale 1ns/10ps

module l1_d_data_array #(
    parameter int NUM_SETS = 64
) (
    input  logic                               clk,
    input  logic                               nrst,
    input  l1_dcache_pkg::stage1_t             s1,
    input  logic                               refill,
    input  logic [l1_dcache_pkg::LINE_W-1:0]   l2_rdata,
    output logic                               resp_valid,
    output logic [l1_dcache_pkg::WORD_W-1:0]   resp_rdata,
    output logic [l1_dcache_pkg::LINE_W-1:0]   victim_line
);
    import l1_dcache_pkg::*;

    localparam int IDX_W = $clog2(NUM_SETS);

    logic [LINE_W-1:0] lines [NUM_SETS];

    logic [IDX_W-1:0]      line_idx;
    logic [OFFSET_W-3:0]   word_sel;
    logic                  rd_hit;
    logic                  wr_hit;

    assign line_idx = s1.addr[OFFSET_W +: IDX_W];
    assign word_sel = s1.addr.offset[OFFSET_W-1:2];

    // A hit sits in the stage register for exactly one cycle.
    assign rd_hit = s1.valid && s1.hit && !s1.write;
    assign wr_hit = s1.valid && s1.hit && s1.write;

    assign victim_line = lines[line_idx]; // Still the old line until the refill edge.

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < NUM_SETS; i++)
                lines[i] <= '0;
        end
        else if (refill)
            lines[line_idx] <= l2_rdata;
        else if (wr_hit)
            lines[line_idx][word_sel*WORD_W +: WORD_W] <= s1.wdata;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            resp_valid <= 1'b0;
        else
            resp_valid <= rd_hit;
    end

    always_ff @(posedge clk)
    begin
        if (rd_hit)
            resp_rdata <= lines[line_idx][word_sel*WORD_W +: WORD_W];
    end

endmodule

/* hw/l1_tag_stage.sv */
`timescale 1ns/10ps

module l1_tag_stage #(
    parameter int NUM_SETS = 64
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     req_valid,
    input  l1_dcache_pkg::core_req_t req,
    input  logic                     tag_fill,
    input  logic                     replay,
    output l1_dcache_pkg::stage1_t   s1,
    output logic                     stall
);
    import l1_dcache_pkg::*;

    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int TAG_LW = WORD_W - OFFSET_W - IDX_W;

    logic [TAG_LW-1:0]   tag_arr [NUM_SETS];
    logic [NUM_SETS-1:0] valid_arr;
    logic [NUM_SETS-1:0] dirty_arr;

    logic      req_q_valid;
    core_req_t req_q;
    stage1_t   s1_q;

    logic              lk_valid;
    core_req_t         lk_req;
    logic [IDX_W-1:0]  lk_idx;
    logic [TAG_LW-1:0] lk_tag;
    logic              lk_hit;
    logic              update;
    logic [IDX_W-1:0]  s1_idx;

    assign s1     = s1_q;
    assign stall  = s1_q.valid && !s1_q.hit;
    assign update = replay || !stall; // The stage register moves or is re-evaluated.
    assign s1_idx = s1_q.addr[OFFSET_W +: IDX_W];

    // A replay looks the held entry up again, otherwise the queued request is looked up.
    always_comb
    begin
        if (replay)
        begin
            lk_valid     = s1_q.valid;
            lk_req.write = s1_q.write;
            lk_req.addr  = s1_q.addr;
            lk_req.wdata = s1_q.wdata;
        end
        else
        begin
            lk_valid = req_q_valid;
            lk_req   = req_q;
        end
        lk_idx = lk_req.addr[OFFSET_W +: IDX_W];
        lk_tag = lk_req.addr[WORD_W-1 -: TAG_LW];
        lk_hit = valid_arr[lk_idx] && (tag_arr[lk_idx] == lk_tag);
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            req_q_valid <= 1'b0;
        else if (!stall)
            req_q_valid <= req_valid;
    end

    always_ff @(posedge clk)
    begin
        if (!stall && req_valid)
            req_q <= req;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            s1_q <= '0;
        else if (update)
        begin
            s1_q.valid        <= lk_valid;
            s1_q.hit          <= lk_hit;
            s1_q.write        <= lk_req.write;
            s1_q.victim_dirty <= valid_arr[lk_idx] && dirty_arr[lk_idx];
            s1_q.victim_tag   <= {tag_arr[lk_idx], lk_idx};
            s1_q.addr         <= lk_req.addr;
            s1_q.wdata        <= lk_req.wdata;
        end
    end

    // A fill never coincides with an update, since the controller waits while stalled.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end
        else if (tag_fill)
        begin
            valid_arr[s1_idx] <= 1'b1;
            dirty_arr[s1_idx] <= 1'b0;
        end
        else if (update && lk_valid && lk_hit && lk_req.write)
            dirty_arr[lk_idx] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (tag_fill)
            tag_arr[s1_idx] <= s1_q.addr[WORD_W-1 -: TAG_LW];
    end

endmodule

/* hw/l1_dcache_pkg.sv */
package l1_dcache_pkg;

    // Geometry of the default configuration with 64 sets of 64-byte lines.
    localparam int WORD_W   = 32;
    localparam int LINE_W   = 512;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 6;
    localparam int TAG_W    = WORD_W - INDEX_W - OFFSET_W;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset; // Bits 5 to 2 select the word.
    } dcache_addr_t;

    typedef struct packed {
        logic              write;
        dcache_addr_t      addr;
        logic [WORD_W-1:0] wdata;
    } core_req_t;

    // Result of the tag lookup, handed to the data array and the miss controller.
    typedef struct packed {
        logic                       valid;
        logic                       hit;
        logic                       write;
        logic                       victim_dirty; // Victim line is valid and modified.
        // Victim tag with the set index below it, so this field is the victim's
        // line address whatever the number of sets.
        logic [WORD_W-OFFSET_W-1:0] victim_tag;
        dcache_addr_t               addr;
        logic [WORD_W-1:0]          wdata;
    } stage1_t;

endpackage
